//--- alu.f
source/alu_pkg.sv
source/alu_shifter.sv
source/alu_muldiv.sv
source/alu_decode.sv
source/alu_execute.sv
source/alu_writeback.sv
source/alu_top.sv
testbench/alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the ALU testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module alu_tb -Mdir obj_dir -o alu_sim -f alu.f \
    && ./obj_dir/alu_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

//--- source/alu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decode (
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire logic                  valid_i,
    input  wire alu_pkg::alu_req_t     req_i,
    output logic                       valid_o,
    output alu_pkg::exec_stage_t       stage_o
);
    import alu_pkg::*;

    alu_ctrl_t ctrl;
    logic [3:0] fn_bits;

    assign fn_bits = req_i.op.fn;

    // same mapping as the combinational control block of the ALU
    // sub is needed for sub and both compares
    assign ctrl.sub          = fn_bits[1] | fn_bits[3];
    assign ctrl.unsigned_cmp = fn_bits[3];
    assign ctrl.shift_right  = fn_bits[2];
    assign ctrl.shift_arith  = fn_bits[3];
    assign ctrl.out_sel      = fn_bits[2:0];
    assign ctrl.word         = req_i.op.word;
    assign ctrl.muldiv       = req_i.op.muldiv;
    assign ctrl.md_sel       = req_i.op.md_sel;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // payload only moves with a valid operation
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            stage_o.ctrl <= ctrl;
            stage_o.src1 <= req_i.src1;
            stage_o.src2 <= req_i.src2;
        end
    end

    // RV64M has no word form of the high-half multiplies
    word_muldiv_legal: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (valid_i && req_i.op.muldiv && req_i.op.word) |->
            (req_i.op.md_sel inside {md_mul, md_div, md_divu, md_rem, md_remu})
    ) else $error("word muldiv with illegal selection %0d", req_i.op.md_sel);

endmodule

`default_nettype wire

//--- source/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
    input  wire logic                   clk_i,
    input  wire logic                   reset_i,
    input  wire logic                   valid_i,
    input  wire alu_pkg::exec_stage_t   stage_i,
    output logic                        valid_o,
    output alu_pkg::wb_stage_t          stage_o
);
    import alu_pkg::*;

    alu_ctrl_t          ctrl;
    logic [xlen-1:0]    src1;
    logic [xlen-1:0]    src2;
    logic [xlen-1:0]    src2_eff;
    logic [xlen-1:0]    sum;
    logic               carry;
    logic               overflow;
    logic               zero;
    logic               less;
    logic [xlen-1:0]    shift_res;
    logic [xlen-1:0]    md_res;
    logic [xlen-1:0]    alu_res;
    logic [xlen-1:0]    raw;

    assign ctrl = stage_i.ctrl;
    assign src1 = stage_i.src1;
    assign src2 = stage_i.src2;

    // subtract as src1 + ~src2 + 1
    assign src2_eff       = src2 ^ {xlen{ctrl.sub}};
    assign {carry, sum}   = {1'b0, src1} + {1'b0, src2_eff} + {{xlen{1'b0}}, ctrl.sub};
    assign overflow       = (src1[xlen-1] == src2_eff[xlen-1]) && (sum[xlen-1] != src1[xlen-1]);
    assign zero           = ~(|sum);

    // unsigned: no carry out of the subtract means borrow
    assign less = ctrl.unsigned_cmp ? (carry ^ ctrl.sub) : (sum[xlen-1] ^ overflow);

    alu_shifter u_shifter (
        .src_i    (src1),
        .amount_i (src2[shamt_w-1:0]),
        .right_i  (ctrl.shift_right),
        .arith_i  (ctrl.shift_arith),
        .word_i   (ctrl.word),
        .shift_o  (shift_res)
    );

    alu_muldiv u_muldiv (
        .src1_i   (src1),
        .src2_i   (src2),
        .sel_i    (ctrl.md_sel),
        .word_i   (ctrl.word),
        .result_o (md_res)
    );

    always_comb begin
        case (ctrl.out_sel)
            sel_add:  alu_res = sum;
            sel_shl,
            sel_shr:  alu_res = shift_res;
            sel_slt:  alu_res = {{(xlen-1){1'b0}}, less};
            sel_pass: alu_res = src2;
            sel_xor:  alu_res = src1 ^ src2;
            sel_or:   alu_res = src1 | src2;
            sel_and:  alu_res = src1 & src2;
            default:  alu_res = sum;
        endcase
    end

    assign raw = ctrl.muldiv ? md_res : alu_res;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            stage_o.word   <= ctrl.word;
            stage_o.result <= raw;
            stage_o.zero   <= zero;
            stage_o.less   <= less;
        end
    end

    // decode must hand over a fully known payload with every valid
    exec_payload_known: assert property (
        @(posedge clk_i) disable iff (reset_i)
        valid_i |-> !$isunknown(stage_i)
    ) else $error("unknown bits in execute payload");

endmodule

`default_nettype wire

//--- source/alu_muldiv.sv
`timescale 1ns/1ps
`default_nettype none

module alu_muldiv (
    input  wire logic [alu_pkg::xlen-1:0] src1_i,
    input  wire logic [alu_pkg::xlen-1:0] src2_i,
    input  wire alu_pkg::md_sel_e         sel_i,
    input  wire logic                     word_i,
    output logic [alu_pkg::xlen-1:0]      result_o
);
    import alu_pkg::*;

    logic                       a_signed;
    logic                       b_signed;
    logic                       div_signed;
    logic [xlen-1:0]            op_a;
    logic [xlen-1:0]            op_b;
    logic signed [xlen:0]       mul_a;
    logic signed [xlen:0]       mul_b;
    logic signed [2*xlen+1:0]   product;
    logic                       div_by_zero;
    logic                       div_overflow;
    logic [xlen-1:0]            divisor;
    logic [xlen-1:0]            quot_s;
    logic [xlen-1:0]            rem_s;
    logic [xlen-1:0]            quot_u;
    logic [xlen-1:0]            rem_u;

    assign a_signed   = sel_i inside {md_mulh, md_mulhsu, md_div, md_rem};
    assign b_signed   = sel_i inside {md_mulh, md_div, md_rem};
    assign div_signed = sel_i inside {md_div, md_rem};

    // word forms work on the low half, extended as the op needs
    assign op_a = word_i ? {{(xlen-word_w){a_signed & src1_i[word_w-1]}},
                            src1_i[word_w-1:0]} : src1_i;
    assign op_b = word_i ? {{(xlen-word_w){b_signed & src2_i[word_w-1]}},
                            src2_i[word_w-1:0]} : src2_i;

    // one signed 65x65 multiplier covers all four products
    assign mul_a   = $signed({a_signed & op_a[xlen-1], op_a});
    assign mul_b   = $signed({b_signed & op_b[xlen-1], op_b});
    assign product = mul_a * mul_b;

    assign div_by_zero  = (op_b == '0);
    assign div_overflow = div_signed && (op_a == {1'b1, {(xlen-1){1'b0}}}) && (op_b == '1);

    // keep the divider free of a zero divisor, the result is replaced anyway
    assign divisor = div_by_zero ? {{(xlen-1){1'b0}}, 1'b1} : op_b;

    assign quot_s = $signed(op_a) / $signed(divisor);
    assign rem_s  = $signed(op_a) % $signed(divisor);
    assign quot_u = op_a / divisor;
    assign rem_u  = op_a % divisor;

    always_comb begin
        case (sel_i)
            md_mul: result_o = product[xlen-1:0];
            md_mulh,
            md_mulhsu,
            md_mulhu: result_o = product[2*xlen-1:xlen];
            md_div: begin
                if (div_by_zero) result_o = '1;
                else if (div_overflow) result_o = op_a;
                else result_o = quot_s;
            end
            md_rem: begin
                if (div_by_zero) result_o = op_a;
                else if (div_overflow) result_o = '0;
                else result_o = rem_s;
            end
            md_divu: result_o = div_by_zero ? '1 : quot_u;
            md_remu: result_o = div_by_zero ? op_a : rem_u;
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // datapath width, fixed by RV64
    localparam int xlen = 64;
    localparam int word_w = 32;
    localparam int shamt_w = 6;

    // base functions, bit 3 picks the variant
    typedef enum logic [3:0] {
        fn_add  = 4'd0,
        fn_shl  = 4'd1,
        fn_slt  = 4'd2,
        fn_pass = 4'd3,
        fn_xor  = 4'd4,
        fn_shr  = 4'd5,
        fn_or   = 4'd6,
        fn_and  = 4'd7,
        fn_sub  = 4'd8,
        fn_sltu = 4'd10,
        fn_sra  = 4'd13
    } alu_fn_e;

    // follows the funct3 field of the M extension
    typedef enum logic [2:0] {
        md_mul    = 3'd0,
        md_mulh   = 3'd1,
        md_mulhsu = 3'd2,
        md_mulhu  = 3'd3,
        md_div    = 3'd4,
        md_divu   = 3'd5,
        md_rem    = 3'd6,
        md_remu   = 3'd7
    } md_sel_e;

    // result select codes, same as fn[2:0]
    localparam logic [2:0] sel_add  = 3'd0;
    localparam logic [2:0] sel_shl  = 3'd1;
    localparam logic [2:0] sel_slt  = 3'd2;
    localparam logic [2:0] sel_pass = 3'd3;
    localparam logic [2:0] sel_xor  = 3'd4;
    localparam logic [2:0] sel_shr  = 3'd5;
    localparam logic [2:0] sel_or   = 3'd6;
    localparam logic [2:0] sel_and  = 3'd7;

    typedef struct packed {
        logic    word;
        logic    muldiv;
        alu_fn_e fn;
        md_sel_e md_sel;
    } alu_op_t;

    typedef struct packed {
        alu_op_t           op;
        logic [xlen-1:0]   src1;
        logic [xlen-1:0]   src2;
    } alu_req_t;

    typedef struct packed {
        logic       sub;
        logic       unsigned_cmp;
        logic       shift_right;
        logic       shift_arith;
        logic [2:0] out_sel;
        logic       word;
        logic       muldiv;
        md_sel_e    md_sel;
    } alu_ctrl_t;

    typedef struct packed {
        alu_ctrl_t         ctrl;
        logic [xlen-1:0]   src1;
        logic [xlen-1:0]   src2;
    } exec_stage_t;

    typedef struct packed {
        logic              word;
        logic [xlen-1:0]   result;
        logic              zero;
        logic              less;
    } wb_stage_t;

    typedef struct packed {
        logic [xlen-1:0]   result;
        logic              zero;
        logic              less;
    } alu_resp_t;

endpackage

`default_nettype wire

//--- source/alu_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module alu_shifter (
    input  wire logic [alu_pkg::xlen-1:0]    src_i,
    input  wire logic [alu_pkg::shamt_w-1:0] amount_i,
    input  wire logic                        right_i,
    input  wire logic                        arith_i,
    input  wire logic                        word_i,
    output logic [alu_pkg::xlen-1:0]         shift_o
);
    import alu_pkg::*;

    function automatic logic [xlen-1:0] bit_reverse(input logic [xlen-1:0] value);
        logic [xlen-1:0] rev;
        for (int i = 0; i < xlen; i++) begin
            rev[i] = value[xlen-1-i];
        end
        return rev;
    endfunction

    logic [shamt_w-1:0]     shamt;
    logic                   fill;
    logic [xlen-1:0]        right_src;
    logic [xlen-1:0]        shift_in;
    logic signed [xlen:0]   shift_ext;
    logic [xlen-1:0]        shifted;

    // word shifts only look at five amount bits
    assign shamt = word_i ? {1'b0, amount_i[shamt_w-2:0]} : amount_i;

    // sign bit comes from bit 31 for word ops
    assign fill = right_i & arith_i & (word_i ? src_i[word_w-1] : src_i[xlen-1]);

    // word right shifts start from the low half with the fill above it
    assign right_src = word_i ? {{(xlen-word_w){fill}}, src_i[word_w-1:0]} : src_i;

    // left shift = reverse, shift right, reverse back
    assign shift_in = right_i ? right_src : bit_reverse(src_i);

    // one right shifter, extra top bit carries the fill
    assign shift_ext = $signed({fill, shift_in}) >>> shamt;
    assign shifted   = shift_ext[xlen-1:0];

    assign shift_o = right_i ? shifted : bit_reverse(shifted);

endmodule

`default_nettype wire

//--- source/alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_top (
    input  wire logic                clk_i,
    input  wire logic                reset_i,
    input  wire logic                valid_i,
    input  wire alu_pkg::alu_req_t   req_i,
    output logic                     valid_o,
    output alu_pkg::alu_resp_t       resp_o
);
    import alu_pkg::*;

    // decode to execute
    logic           s1_valid;
    exec_stage_t    s1;

    // execute to writeback
    logic           s2_valid;
    wb_stage_t      s2;

    alu_decode u_decode (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .req_i   (req_i),
        .valid_o (s1_valid),
        .stage_o (s1)
    );

    alu_execute u_execute (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (s1_valid),
        .stage_i (s1),
        .valid_o (s2_valid),
        .stage_o (s2)
    );

    alu_writeback u_writeback (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (s2_valid),
        .stage_i (s2),
        .valid_o (valid_o),
        .resp_o  (resp_o)
    );

endmodule

`default_nettype wire

//--- source/alu_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module alu_writeback (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire logic                 valid_i,
    input  wire alu_pkg::wb_stage_t   stage_i,
    output logic                      valid_o,
    output alu_pkg::alu_resp_t        resp_o
);
    import alu_pkg::*;

    logic [xlen-1:0] result;

    // word results are sign extended from bit 31
    assign result = stage_i.word ?
                    {{(xlen-word_w){stage_i.result[word_w-1]}}, stage_i.result[word_w-1:0]} :
                    stage_i.result;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            resp_o.result <= result;
            resp_o.zero   <= stage_i.zero;
            resp_o.less   <= stage_i.less;
        end
    end

    // no stale response may leave right after reset
    no_valid_after_reset: assert property (
        @(posedge clk_i) reset_i |=> !valid_o
    ) else $error("valid_o high in the cycle after reset");

endmodule

`default_nettype wire

//--- testbench/alu_stim.txt
# group word muldiv fn md_sel src1 src2 result zero less
# all columns hex, fn and md_sel use the alu_pkg codes
1 0 0 0 0 0000000000000005 0000000000000003 0000000000000008 0 0
1 0 0 0 0 ffffffffffffffff 0000000000000001 0000000000000000 1 0
1 0 0 0 0 7fffffffffffffff 0000000000000001 8000000000000000 0 0
1 0 0 8 0 0000000000000003 0000000000000005 fffffffffffffffe 0 1
1 0 0 8 0 0000000000000005 0000000000000005 0000000000000000 1 0
1 1 0 0 0 000000007fffffff 0000000000000001 ffffffff80000000 0 0
1 1 0 8 0 0000000100000000 0000000000000001 ffffffffffffffff 0 0
1 1 0 0 0 00000001fffffffe 0000000000000003 0000000000000001 0 0
1 1 0 0 0 0000000100000000 0000000000000000 0000000000000000 0 0
2 0 0 2 0 ffffffffffffffff 0000000000000001 0000000000000001 0 1
2 0 0 a 0 ffffffffffffffff 0000000000000001 0000000000000000 0 0
2 0 0 2 0 8000000000000000 0000000000000000 0000000000000001 0 1
2 0 0 a 0 8000000000000000 0000000000000000 0000000000000000 0 0
2 0 0 2 0 0000000000000000 8000000000000000 0000000000000000 0 0
2 0 0 a 0 0000000000000000 8000000000000000 0000000000000001 0 1
2 0 0 2 0 0000000000000005 0000000000000005 0000000000000000 1 0
3 0 0 1 0 8000000000000001 0000000000000000 8000000000000001 0 1
3 0 0 1 0 8000000000000001 0000000000000001 0000000000000002 0 1
3 0 0 1 0 0000000000000001 000000000000003f 8000000000000000 0 0
3 0 0 5 0 8000000000000000 0000000000000020 0000000080000000 0 1
3 0 0 5 0 ffffffffffffffff 000000000000003f 0000000000000001 0 0
3 0 0 d 0 8000000000000000 000000000000001f ffffffff00000000 0 0
3 1 0 1 0 0000000000000001 000000000000001f ffffffff80000000 0 0
3 1 0 1 0 0000000000000003 0000000000000021 0000000000000006 0 0
3 1 0 5 0 ffffffff80000000 000000000000001f 0000000000000001 0 1
3 1 0 d 0 0000000080000000 0000000000000004 fffffffff8000000 0 0
3 0 0 4 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 1
3 0 0 6 0 f0f0f0f0f0f0f0f0 0f0f0f0f0f0f0f0f ffffffffffffffff 0 1
3 0 0 7 0 f0f0f0f0f0f0f0f0 0f0f0f0f0f0f0f0f 0000000000000000 0 1
3 0 0 3 0 0000000000000001 123456789abcdef0 123456789abcdef0 0 1
4 0 1 0 0 fffffffffffffff9 0000000000000003 ffffffffffffffeb 0 1
4 0 1 0 1 fffffffffffffff9 0000000000000003 ffffffffffffffff 0 1
4 0 1 0 3 fffffffffffffff9 0000000000000003 0000000000000002 0 1
4 0 1 0 2 0000000000000003 fffffffffffffff9 0000000000000002 0 1
4 0 1 0 2 fffffffffffffff9 fffffffffffffffd fffffffffffffff9 0 1
4 0 1 0 4 fffffffffffffff9 0000000000000002 fffffffffffffffd 0 1
4 0 1 0 6 fffffffffffffff9 0000000000000002 ffffffffffffffff 0 1
4 0 1 0 5 fffffffffffffff9 0000000000000002 7ffffffffffffffc 0 1
4 0 1 0 7 fffffffffffffff9 0000000000000002 0000000000000001 0 1
4 0 1 0 4 0000000000000007 0000000000000000 ffffffffffffffff 0 0
4 0 1 0 6 fffffffffffffff9 0000000000000000 fffffffffffffff9 0 1
4 0 1 0 5 0000000000000007 0000000000000000 ffffffffffffffff 0 0
4 0 1 0 7 0000000000000007 0000000000000000 0000000000000007 0 0
4 0 1 0 4 8000000000000000 ffffffffffffffff 8000000000000000 0 1
4 0 1 0 6 8000000000000000 ffffffffffffffff 0000000000000000 0 1
4 1 1 0 0 0000000100000003 00000000ffffffff fffffffffffffffd 0 0
4 1 1 0 4 00000000fffffff9 0000000000000002 fffffffffffffffd 0 0
4 1 1 0 5 00000000fffffff9 0000000000000002 000000007ffffffc 0 0
4 1 1 0 6 00000000fffffff9 0000000000000002 ffffffffffffffff 0 0
4 1 1 0 7 00000000fffffff9 0000000000000002 0000000000000001 0 0
4 1 1 0 4 00000000fffffff9 ffffffff00000000 ffffffffffffffff 0 1
4 1 1 0 4 0000000080000000 00000000ffffffff ffffffff80000000 0 0

//--- testbench/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb;
    import alu_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int latency      = 3;
    localparam int drain_limit  = 20;

    // expected response and the edge after which it must be on the outputs
    typedef struct packed {
        logic [31:0] arrive_edge;
        alu_resp_t   resp;
    } expect_t;

    logic      clk_i;
    logic      reset_i;
    logic      valid_i;
    alu_req_t  req_i;
    logic      valid_o;
    alu_resp_t resp_o;

    expect_t   expect_q[$];
    expect_t   head;
    int        cycle = 0;
    int        checks = 0;
    int        errors = 0;
    int        run_failures = 0;
    int        mark_checks = 0;
    int        mark_errors = 0;
    integer    seed = 57154;

    alu_top DUT (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .req_i   (req_i),
        .valid_o (valid_o),
        .resp_o  (resp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(clk_period / 2) clk_i = ~clk_i;
    end

    // rising edges seen so far
    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    task automatic compare(input string name, input logic [xlen-1:0] got,
                           input logic [xlen-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // outputs are stable around the falling edge
    always @(negedge clk_i) begin
        if (cycle == reset_cycles) begin
            compare("valid_o", 64'(valid_o), 64'd0);
        end
        if (valid_o === 1'b1) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("valid_o went high with no operation in flight at edge %0d", cycle);
            end else begin
                head = expect_q.pop_front();
                compare("valid_o arrival edge", 64'(cycle), 64'(head.arrive_edge));
                compare("resp_o.result", resp_o.result, head.resp.result);
                compare("resp_o.zero", 64'(resp_o.zero), 64'(head.resp.zero));
                compare("resp_o.less", 64'(resp_o.less), 64'(head.resp.less));
            end
        end
    end

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk_i);
            valid_i <= 1'b0;
        end
    endtask

    task automatic issue(input alu_req_t req, input alu_resp_t resp);
        expect_t entry;
        @(posedge clk_i);
        valid_i <= 1'b1;
        req_i   <= req;
        // counter update for this edge is still pending
        entry.arrive_edge = cycle + 1 + latency;
        entry.resp        = resp;
        expect_q.push_back(entry);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (expect_q.size() != 0 && waited < drain_limit) begin
            @(posedge clk_i);
            waited++;
        end
        if (expect_q.size() != 0) begin
            run_failures++;
            $display("timeout: %0d results still missing after %0d cycles",
                     expect_q.size(), drain_limit);
            expect_q.delete();
        end
    endtask

    function automatic string group_name(input int grp);
        case (grp)
            0: return "reset state";
            1: return "add and subtract";
            2: return "compares";
            3: return "shifts and logic";
            4: return "multiply and divide";
            default: return "unnamed";
        endcase
    endfunction

    task automatic close_group(input int grp);
        idle(1);
        drain();
        $display("group %0d (%s): %0d checks, %0d errors", grp, group_name(grp),
                 checks - mark_checks, errors + run_failures - mark_errors);
        mark_checks = checks;
        mark_errors = errors + run_failures;
    endtask

    initial begin
        int              fd;
        int              fields;
        int              gap;
        int              cur_group;
        string           line;
        logic [31:0]     group_id;
        logic            word;
        logic            muldiv;
        logic [3:0]      fn;
        logic [2:0]      sel;
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
        logic [xlen-1:0] result;
        logic            zero;
        logic            less;
        alu_req_t        req;
        alu_resp_t       resp;

        // requests offered during reset must never come out
        reset_i = 1'b1;
        valid_i = 1'b1;
        req_i   = '0;
        cur_group = -1;
        repeat (reset_cycles) @(posedge clk_i);
        reset_i <= 1'b0;
        valid_i <= 1'b0;
        @(posedge clk_i);
        close_group(0);

        fd = $fopen("testbench/alu_stim.txt", "r");
        if (fd == 0) begin
            run_failures++;
            $display("could not open the stimulus file testbench/alu_stim.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", group_id, word,
                                 muldiv, fn, sel, src1, src2, result, zero, less);
                // comment and blank lines do not parse
                if (fields == 10) begin
                    if (cur_group >= 0 && int'(group_id) != cur_group) begin
                        close_group(cur_group);
                    end
                    cur_group = int'(group_id);
                    // first group runs back to back
                    if (cur_group == 1) begin
                        gap = 0;
                    end else begin
                        gap = $random(seed) % 3;
                        if (gap < 0) begin
                            gap = -gap;
                        end
                    end
                    idle(gap);
                    req.op.word   = word;
                    req.op.muldiv = muldiv;
                    req.op.fn     = alu_fn_e'(fn);
                    req.op.md_sel = md_sel_e'(sel);
                    req.src1      = src1;
                    req.src2      = src2;
                    resp.result   = result;
                    resp.zero     = zero;
                    resp.less     = less;
                    issue(req, resp);
                end
            end
            $fclose(fd);
            if (cur_group >= 0) begin
                close_group(cur_group);
            end
        end

        $display("summary: %0d checks, %0d errors, %0d other failures",
                 checks, errors, run_failures);
        if (errors == 0 && run_failures == 0 && checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
